// ==== Bender.yml ====
package:
  name: ppu

sources:
  - hw/ppu_pkg.sv
  - hw/ppu_vram.sv
  - hw/ppu_bus_slave.sv
  - hw/ppu_line_timer.sv
  - hw/ppu_bg_fetcher.sv
  - hw/ppu_row_fifo.sv
  - hw/ppu_pixel_shifter.sv
  - hw/ppu_top.sv
  - target: test
    files:
      - testbench/tb_ppu.sv

// ==== filelist.f ====
hw/ppu_pkg.sv
hw/ppu_vram.sv
hw/ppu_bus_slave.sv
hw/ppu_line_timer.sv
hw/ppu_bg_fetcher.sv
hw/ppu_row_fifo.sv
hw/ppu_pixel_shifter.sv
hw/ppu_top.sv
testbench/tb_ppu.sv

// ==== hw/ppu_bg_fetcher.sv ====
module ppu_bg_fetcher (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::ppu_regs_t regs,
  input  logic [7:0]         ly,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic               line_start,
  input  logic [7:0]         vram_rdata,
  input  logic               full,
  output logic [12:0]        vram_addr,
  output logic               push,
  output ppu_pkg::tile_row_t row
);

  // One row per four cycles: map, low, high, push
  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_MAP,
    FETCH_LO,
    FETCH_HI,
    FETCH_PUSH
  } fetch_state_t;

  fetch_state_t state;
  logic [4:0]   col;
  logic [7:0]   tile_q;
  logic [7:0]   lo_q;
  logic [7:0]   y;
  logic [12:0]  map_base;

  // 16 bytes per tile, signed mode based at 0x9000
  function automatic logic [12:0] tile_addr(
    input logic [7:0] idx,
    input logic [2:0] fine_y,
    input logic       unsigned_mode,
    input logic       hi
  );
    tile_addr = {~unsigned_mode & ~idx[7], idx, fine_y, hi};
  endfunction

  // Background row with vertical scroll, wraps at 256
  assign y        = ly + regs.scy;
  assign map_base = regs.lcdc[3] ? 13'h1C00 : 13'h1800;

  // Address for the byte that lands in the next state
  always_comb begin
    case (state)
      FETCH_LO:   vram_addr = tile_addr(vram_rdata, y[2:0], regs.lcdc[4], 1'b0);
      FETCH_HI,
      FETCH_PUSH: vram_addr = tile_addr(tile_q, y[2:0], regs.lcdc[4], 1'b1);
      default:    vram_addr = map_base + {3'b000, y[7:3], col};
    endcase
  end

  // High byte comes straight from VRAM, held while stalled
  assign push = (state == FETCH_PUSH) && !full;
  assign row  = '{lo: lo_q, hi: vram_rdata};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= FETCH_IDLE;
      col   <= 5'd0;
    end else if (mode != ppu_pkg::MODE_XFER) begin
      state <= FETCH_IDLE;
    end else if (line_start) begin
      state <= FETCH_MAP;
      col   <= regs.scx[7:3];
    end else begin
      case (state)
        FETCH_MAP: state <= FETCH_LO;
        FETCH_LO:  state <= FETCH_HI;
        FETCH_HI:  state <= FETCH_PUSH;
        FETCH_PUSH: begin
          // Back-pressure from the FIFO
          if (!full) begin
            state <= FETCH_MAP;
            col   <= col + 5'd1;
          end
        end
        default: ;
      endcase
    end
  end

  // Tile index and low plane
  always_ff @(posedge clk) begin
    if (state == FETCH_LO) begin
      tile_q <= vram_rdata;
    end
    if (state == FETCH_HI) begin
      lo_q <= vram_rdata;
    end
  end

endmodule

// ==== hw/ppu_bus_slave.sv ====
module ppu_bus_slave (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::wb_req_t   wb_req,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         ly,
  input  logic               coincidence,
  input  logic [7:0]         vram_rdata,
  output ppu_pkg::wb_rsp_t   wb_rsp,
  output ppu_pkg::ppu_regs_t regs,
  output logic [12:0]        vram_cpu_addr,
  output logic               vram_cpu_we,
  output logic               vram_cpu_re,
  output logic [7:0]         vram_cpu_wdata
);

  logic [7:0] oam [ppu_pkg::OAM_END - ppu_pkg::OAM_START + 1];
  logic [7:0] oam_idx;

  logic       ack;
  logic       req;
  logic       vram_sel;
  logic       oam_sel;
  logic       vram_ok;
  logic       oam_ok;
  logic [7:0] reg_rdata;
  logic [7:0] rd_data;
  logic       rd_vram;

  // ====================================================================
  // Decode and mode blocking
  // ====================================================================

  // New request only while not already acking
  assign req = wb_req.cyc && wb_req.stb && !ack;

  assign vram_sel = (wb_req.adr >= ppu_pkg::VRAM_START) && (wb_req.adr <= ppu_pkg::VRAM_END);
  assign oam_sel  = (wb_req.adr >= ppu_pkg::OAM_START) && (wb_req.adr <= ppu_pkg::OAM_END);

  // VRAM locked during transfer, OAM during scan and transfer
  assign vram_ok = vram_sel && (mode != ppu_pkg::MODE_XFER);
  assign oam_ok  = oam_sel && (mode != ppu_pkg::MODE_XFER) && (mode != ppu_pkg::MODE_OAM);

  assign oam_idx = 8'(wb_req.adr - ppu_pkg::OAM_START);

  // VRAM CPU port, strobed only for allowed accesses
  assign vram_cpu_addr  = wb_req.adr[12:0];
  assign vram_cpu_wdata = wb_req.dat;
  assign vram_cpu_we    = req && wb_req.we && vram_ok;
  assign vram_cpu_re    = req && !wb_req.we && vram_ok;

  // Register read mux, open bus elsewhere
  always_comb begin
    case (wb_req.adr)
      ppu_pkg::REG_LCDC: reg_rdata = regs.lcdc;
      ppu_pkg::REG_STAT: reg_rdata = {1'b1, regs.stat_en, coincidence, mode};
      ppu_pkg::REG_SCY:  reg_rdata = regs.scy;
      ppu_pkg::REG_SCX:  reg_rdata = regs.scx;
      ppu_pkg::REG_LY:   reg_rdata = ly;
      ppu_pkg::REG_LYC:  reg_rdata = regs.lyc;
      ppu_pkg::REG_BGP:  reg_rdata = regs.bgp;
      default:           reg_rdata = 8'hFF;
    endcase
  end

  // ====================================================================
  // Ack and register file
  // ====================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack     <= 1'b0;
      rd_vram <= 1'b0;
      regs    <= '0;
    end else begin
      ack <= req;
      // VRAM data arrives from the memory itself with the ack
      if (req) begin
        rd_vram <= vram_ok && !wb_req.we;
      end
      if (req && wb_req.we) begin
        case (wb_req.adr)
          ppu_pkg::REG_LCDC: regs.lcdc <= wb_req.dat;
          // Only the enables are writable
          ppu_pkg::REG_STAT: regs.stat_en <= wb_req.dat[6:3];
          ppu_pkg::REG_SCY:  regs.scy <= wb_req.dat;
          ppu_pkg::REG_SCX:  regs.scx <= wb_req.dat;
          ppu_pkg::REG_LYC:  regs.lyc <= wb_req.dat;
          ppu_pkg::REG_BGP:  regs.bgp <= wb_req.dat;
          // LY and unmapped writes dropped
          default: ;
        endcase
      end
    end
  end

  // OAM array and read data
  always_ff @(posedge clk) begin
    if (req && wb_req.we && oam_ok) begin
      oam[oam_idx] <= wb_req.dat;
    end
    if (req) begin
      rd_data <= oam_ok ? oam[oam_idx] : reg_rdata;
    end
  end

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rd_vram ? vram_rdata : rd_data;

endmodule

// ==== hw/ppu_line_timer.sv ====
module ppu_line_timer (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::ppu_regs_t regs,
  input  logic               line_done,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               coincidence,
  output logic               line_start,
  output ppu_pkg::ppu_irq_t  irq
);

  logic [8:0]         dot;
  logic [8:0]         dot_n;
  logic [7:0]         ly_n;
  ppu_pkg::ppu_mode_t mode_n;
  logic               lcd_on;
  logic               line_end;
  logic               stat_hit;

  assign lcd_on   = regs.lcdc[7];
  assign line_end = (dot == 9'(ppu_pkg::DOTS_PER_LINE - 1));

  // ====================================================================
  // Next dot, line and mode
  // ====================================================================

  always_comb begin
    dot_n  = line_end ? 9'd0 : dot + 9'd1;
    ly_n   = ly;
    mode_n = mode;
    if (line_end) begin
      ly_n = (ly == 8'(ppu_pkg::LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
    end
    case (mode)
      ppu_pkg::MODE_OAM: begin
        if (dot == 9'(ppu_pkg::MODE2_LEN - 1)) begin
          mode_n = ppu_pkg::MODE_XFER;
        end
      end
      // Variable length, ended by the shifter
      ppu_pkg::MODE_XFER: begin
        if (line_done) begin
          mode_n = ppu_pkg::MODE_HBLANK;
        end
      end
      ppu_pkg::MODE_HBLANK: begin
        if (line_end) begin
          mode_n = (ly == 8'(ppu_pkg::SCREEN_HEIGHT - 1)) ? ppu_pkg::MODE_VBLANK
                                                           : ppu_pkg::MODE_OAM;
        end
      end
      default: begin
        if (line_end && ly == 8'(ppu_pkg::LINES_PER_FRAME - 1)) begin
          mode_n = ppu_pkg::MODE_OAM;
        end
      end
    endcase
    // LCD off parks the timer at line 0, mode 2
    if (!lcd_on) begin
      dot_n  = 9'd0;
      ly_n   = 8'd0;
      mode_n = ppu_pkg::MODE_OAM;
    end
  end

  // STAT sources, LYC match on LY change or entry to an enabled mode
  always_comb begin
    stat_hit = regs.stat_en[3] && (ly_n != ly) && (ly_n == regs.lyc);
    if (mode_n != mode) begin
      case (mode_n)
        ppu_pkg::MODE_HBLANK: stat_hit = stat_hit || regs.stat_en[0];
        ppu_pkg::MODE_VBLANK: stat_hit = stat_hit || regs.stat_en[1];
        ppu_pkg::MODE_OAM:    stat_hit = stat_hit || regs.stat_en[2];
        default: ;
      endcase
    end
  end

  // ====================================================================
  // State and pulses
  // ====================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot         <= 9'd0;
      ly          <= 8'd0;
      mode        <= ppu_pkg::MODE_OAM;
      coincidence <= 1'b0;
      line_start  <= 1'b0;
      irq         <= '0;
    end else begin
      dot         <= dot_n;
      ly          <= ly_n;
      mode        <= mode_n;
      // Tracks the new LY value
      coincidence <= (ly_n == regs.lyc);
      // High in the first dot of mode 3
      line_start  <= (mode_n == ppu_pkg::MODE_XFER) && (mode != ppu_pkg::MODE_XFER);
      // Same edge that loads LY = 144
      irq.vblank  <= lcd_on && line_end && (ly == 8'(ppu_pkg::SCREEN_HEIGHT - 1));
      irq.stat    <= lcd_on && stat_hit;
    end
  end

endmodule

// ==== hw/ppu_pixel_shifter.sv ====
module ppu_pixel_shifter (
  input  logic               clk,
  input  logic               reset,
  input  logic               line_start,
  input  ppu_pkg::ppu_regs_t regs,
  input  ppu_pkg::tile_row_t rdata,
  input  logic               empty,
  output logic               pop,
  output ppu_pkg::pixel_t    pixel,
  output logic               line_done
);

  logic       active;
  logic [3:0] cnt;       // Pixels left in the shift register
  logic [2:0] discard;   // Fine-scroll pixels still to drop
  logic [7:0] px_count;
  logic [7:0] lo_sr;
  logic [7:0] hi_sr;
  logic [1:0] color;
  logic       emit;

  // Reload only once the register is drained
  assign pop   = active && (cnt == 4'd0) && !empty;
  assign emit  = active && regs.lcdc[7] && (cnt != 4'd0) && (discard == 3'd0);
  // MSB first, high plane is bit 1
  assign color = {hi_sr[7], lo_sr[7]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      cnt       <= 4'd0;
      discard   <= 3'd0;
      px_count  <= 8'd0;
      pixel     <= '0;
      line_done <= 1'b0;
    end else begin
      // Shade through BGP
      pixel     <= '{valid: emit, shade: regs.bgp[{color, 1'b0} +: 2]};
      line_done <= 1'b0;
      if (!regs.lcdc[7]) begin
        active <= 1'b0;
      end else if (line_start) begin
        active   <= 1'b1;
        cnt      <= 4'd0;
        discard  <= regs.scx[2:0];
        px_count <= 8'd0;
      end else if (pop) begin
        cnt <= 4'd8;
      end else if (active && cnt != 4'd0) begin
        cnt <= cnt - 4'd1;
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          px_count <= px_count + 8'd1;
          // Last visible pixel, idle until next line
          if (px_count == 8'(ppu_pkg::SCREEN_WIDTH - 1)) begin
            active    <= 1'b0;
            line_done <= 1'b1;
          end
        end
      end
    end
  end

  // Pixel planes
  always_ff @(posedge clk) begin
    if (pop) begin
      lo_sr <= rdata.lo;
      hi_sr <= rdata.hi;
    end else if (cnt != 4'd0) begin
      lo_sr <= {lo_sr[6:0], 1'b0};
      hi_sr <= {hi_sr[6:0], 1'b0};
    end
  end

endmodule

// ==== hw/ppu_pkg.sv ====
package ppu_pkg;

  // ====================================================================
  // Line and frame timing
  // ====================================================================

  // One dot per clock
  localparam int DOTS_PER_LINE   = 456;
  // OAM scan occupies dots 0..79
  localparam int MODE2_LEN       = 80;
  localparam int SCREEN_WIDTH    = 160;
  localparam int SCREEN_HEIGHT   = 144;
  // 144 visible lines plus 10 VBlank lines
  localparam int LINES_PER_FRAME = 154;

  // Row FIFO geometry
  localparam int FIFO_AW    = 2;
  localparam int FIFO_DEPTH = 1 << FIFO_AW;

  // ====================================================================
  // CPU address map
  // ====================================================================

  localparam logic [15:0] VRAM_START = 16'h8000;
  localparam logic [15:0] VRAM_END   = 16'h9FFF;
  localparam logic [15:0] OAM_START  = 16'hFE00;
  localparam logic [15:0] OAM_END    = 16'hFE9F;

  // LCD registers, FF46 (DMA) not mapped here
  localparam logic [15:0] REG_LCDC = 16'hFF40;
  localparam logic [15:0] REG_STAT = 16'hFF41;
  localparam logic [15:0] REG_SCY  = 16'hFF42;
  localparam logic [15:0] REG_SCX  = 16'hFF43;
  localparam logic [15:0] REG_LY   = 16'hFF44;
  localparam logic [15:0] REG_LYC  = 16'hFF45;
  localparam logic [15:0] REG_BGP  = 16'hFF47;

  // ====================================================================
  // Types
  // ====================================================================

  // Encoded as in STAT[1:0]
  typedef enum logic [1:0] {
    MODE_HBLANK = 2'd0,
    MODE_VBLANK = 2'd1,
    MODE_OAM    = 2'd2,
    MODE_XFER   = 2'd3
  } ppu_mode_t;

  // Software-visible register state
  typedef struct packed {
    logic [7:0] lcdc;
    logic [3:0] stat_en;  // STAT[6:3]: LYC, mode 2, mode 1, mode 0
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
  } ppu_regs_t;

  // Wishbone classic, 8-bit data
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [7:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  // One 8-pixel row of a tile, bitplanes
  typedef struct packed {
    logic [7:0] lo;
    logic [7:0] hi;
  } tile_row_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] shade;
  } pixel_t;

  typedef struct packed {
    logic vblank;
    logic stat;
  } ppu_irq_t;

endpackage

// ==== hw/ppu_row_fifo.sv ====
module ppu_row_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  logic               push,
  input  ppu_pkg::tile_row_t wdata,
  input  logic               pop,
  output ppu_pkg::tile_row_t rdata,
  output logic               full,
  output logic               empty
);

  ppu_pkg::tile_row_t mem [ppu_pkg::FIFO_DEPTH];

  // Extra MSB tells full from empty
  logic [ppu_pkg::FIFO_AW:0] wr_ptr;
  logic [ppu_pkg::FIFO_AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr == {~rd_ptr[ppu_pkg::FIFO_AW], rd_ptr[ppu_pkg::FIFO_AW-1:0]});
  assign rdata = mem[rd_ptr[ppu_pkg::FIFO_AW-1:0]];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full && !flush) begin
      mem[wr_ptr[ppu_pkg::FIFO_AW-1:0]] <= wdata;
    end
  end

endmodule

// ==== hw/ppu_top.sv ====
module ppu_top (
  input  logic             clk,
  input  logic             reset,
  input  ppu_pkg::wb_req_t wb_req,
  output ppu_pkg::wb_rsp_t wb_rsp,
  output ppu_pkg::pixel_t  pixel,
  output ppu_pkg::ppu_irq_t irq
);

  // Register and status
  ppu_pkg::ppu_regs_t regs;
  ppu_pkg::ppu_mode_t mode;
  logic [7:0]         ly;
  logic               coincidence;
  logic               line_start;
  logic               line_done;

  // VRAM ports
  logic [12:0] vram_cpu_addr;
  logic        vram_cpu_we;
  logic        vram_cpu_re;
  logic [7:0]  vram_cpu_wdata;
  logic [7:0]  vram_cpu_rdata;
  logic [12:0] fetch_addr;
  logic [7:0]  fetch_rdata;

  // Row FIFO
  ppu_pkg::tile_row_t fifo_wdata;
  ppu_pkg::tile_row_t fifo_rdata;
  logic               push;
  logic               pop;
  logic               full;
  logic               empty;

  ppu_bus_slave bus_slave_inst (
    .clk           (clk),
    .reset         (reset),
    .wb_req        (wb_req),
    .mode          (mode),
    .ly            (ly),
    .coincidence   (coincidence),
    .vram_rdata    (vram_cpu_rdata),
    .wb_rsp        (wb_rsp),
    .regs          (regs),
    .vram_cpu_addr (vram_cpu_addr),
    .vram_cpu_we   (vram_cpu_we),
    .vram_cpu_re   (vram_cpu_re),
    .vram_cpu_wdata(vram_cpu_wdata)
  );

  ppu_vram vram_inst (
    .clk        (clk),
    .cpu_addr   (vram_cpu_addr),
    .cpu_we     (vram_cpu_we),
    .cpu_re     (vram_cpu_re),
    .cpu_wdata  (vram_cpu_wdata),
    .fetch_addr (fetch_addr),
    .cpu_rdata  (vram_cpu_rdata),
    .fetch_rdata(fetch_rdata)
  );

  ppu_line_timer line_timer_inst (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .line_done  (line_done),
    .mode       (mode),
    .ly         (ly),
    .coincidence(coincidence),
    .line_start (line_start),
    .irq        (irq)
  );

  ppu_bg_fetcher bg_fetcher_inst (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .ly        (ly),
    .mode      (mode),
    .line_start(line_start),
    .vram_rdata(fetch_rdata),
    .full      (full),
    .vram_addr (fetch_addr),
    .push      (push),
    .row       (fifo_wdata)
  );

  // Flushed on every line start
  ppu_row_fifo row_fifo_inst (
    .clk  (clk),
    .reset(reset),
    .flush(line_start),
    .push (push),
    .wdata(fifo_wdata),
    .pop  (pop),
    .rdata(fifo_rdata),
    .full (full),
    .empty(empty)
  );

  ppu_pixel_shifter pixel_shifter_inst (
    .clk       (clk),
    .reset     (reset),
    .line_start(line_start),
    .regs      (regs),
    .rdata     (fifo_rdata),
    .empty     (empty),
    .pop       (pop),
    .pixel     (pixel),
    .line_done (line_done)
  );

endmodule

// ==== hw/ppu_vram.sv ====
module ppu_vram (
  input  logic        clk,
  input  logic [12:0] cpu_addr,
  input  logic        cpu_we,
  input  logic        cpu_re,
  input  logic [7:0]  cpu_wdata,
  input  logic [12:0] fetch_addr,
  output logic [7:0]  cpu_rdata,
  output logic [7:0]  fetch_rdata
);

  // 8 KiB, one write port and two read ports
  logic [7:0] mem [ppu_pkg::VRAM_END - ppu_pkg::VRAM_START + 1];

  always_ff @(posedge clk) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    // CPU read only on request
    if (cpu_re) begin
      cpu_rdata <= mem[cpu_addr];
    end
    // Fetcher reads every cycle
    fetch_rdata <= mem[fetch_addr];
  end

endmodule

// ==== testbench/tb_ppu.sv ====
module tb_ppu;

  // ====================================================================
  // Timing, limits and random source
  // ====================================================================

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 4;
  // Cycles to wait for a bus acknowledge
  localparam int BUS_TIMEOUT  = 16;
  localparam int FRAME_CYCLES = ppu_pkg::DOTS_PER_LINE * ppu_pkg::LINES_PER_FRAME;
  localparam int FRAME_PIXELS = ppu_pkg::SCREEN_WIDTH * ppu_pkg::SCREEN_HEIGHT;
  // Frames spent with the LCD on, summed over all tests
  localparam int TEST_FRAMES  = 6;
  // Covers the VRAM load of the pixel test and the polling loops
  localparam int MARGIN_CYCLES   = 50000;
  localparam int WATCHDOG_CYCLES = TEST_FRAMES * FRAME_CYCLES + MARGIN_CYCLES;
  localparam int NUM_SAMPLES  = 16;
  localparam int VRAM_BYTES   = 8192;
  localparam int OAM_BYTES    = 160;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED = 32'd79281;

  logic              clk;
  logic              reset;
  ppu_pkg::wb_req_t  wb_req;
  ppu_pkg::wb_rsp_t  wb_rsp;
  ppu_pkg::pixel_t   pixel;
  ppu_pkg::ppu_irq_t irq;

  int          mismatches;
  int          failures;
  int          stat_count;
  logic [31:0] lfsr_state;

  // Expected memory contents
  logic [7:0]  vram_model [VRAM_BYTES];
  logic [7:0]  oam_model [OAM_BYTES];
  logic [12:0] vram_addrs [NUM_SAMPLES];
  logic [7:0]  oam_offs [NUM_SAMPLES];

  // Register values used by the pixel reference
  logic [7:0] pix_lcdc;
  logic [7:0] pix_scx;
  logic [7:0] pix_scy;
  logic [7:0] pix_bgp;

  ppu_top ppu_top_inst (
    .clk   (clk),
    .reset (reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .pixel (pixel),
    .irq   (irq)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  // STAT pulse counter
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      stat_count <= 0;
    end else if (irq.stat) begin
      stat_count <= stat_count + 1;
    end
  end

  // ====================================================================
  // Helpers
  // ====================================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      lfsr_step = (s >> 1) ^ LFSR_TAPS;
    end else begin
      lfsr_step = s >> 1;
    end
  endfunction

  // One LFSR step per bit
  task automatic rand_bits(input int n, output logic [15:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Inputs change and outputs are sampled here
  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, what, exp, got);
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
  endtask

  // Wishbone classic cycle, holds until ack then idles a cycle
  task automatic wb_access(input logic we, input logic [15:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    waited = 0;
    do begin
      step();
      waited++;
    end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
    assert (wb_rsp.ack) else begin
      failures++;
      $display("Bus access to address %h was never acknowledged", adr);
    end
    rdat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    step();
  endtask

  task automatic wb_write(input logic [15:0] adr, input logic [7:0] data);
    logic [7:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [15:0] adr, output logic [7:0] data);
    wb_access(1'b0, adr, 8'h00, data);
  endtask

  // Poll STAT mode bits
  task automatic wait_mode(input logic [1:0] m);
    logic [7:0] stat;
    do begin
      wb_read(ppu_pkg::REG_STAT, stat);
    end while (stat[1:0] !== m);
  endtask

  // Always waits for a new pulse
  task automatic wait_vblank();
    do begin
      step();
    end while (!irq.vblank);
  endtask

  // Background reference: scroll, map lookup, tile addressing, BGP
  function automatic logic [1:0] expected_shade(input int x, input int line);
    int         bg_x;
    int         bg_y;
    int         map_addr;
    int         tile_base;
    int         bit_pos;
    logic [7:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    bg_x     = (x + pix_scx) % 256;
    bg_y     = (line + pix_scy) % 256;
    map_addr = (pix_lcdc[3] ? 7168 : 6144) + (bg_y / 8) * 32 + bg_x / 8;
    idx      = vram_model[map_addr];
    // Signed indices are relative to 0x9000
    if (pix_lcdc[4]) begin
      tile_base = 16 * int'(idx);
    end else begin
      tile_base = 4096 + 16 * int'($signed(idx));
    end
    lo      = vram_model[tile_base + (bg_y % 8) * 2];
    hi      = vram_model[tile_base + (bg_y % 8) * 2 + 1];
    bit_pos = 7 - bg_x % 8;
    color   = {hi[bit_pos], lo[bit_pos]};
    expected_shade = pix_bgp[color * 2 +: 2];
  endfunction

  // ====================================================================
  // Tests
  // ====================================================================

  task automatic reset_state();
    check_eq("ack after reset", wb_rsp.ack, 1'b0);
    check_eq("pixel valid after reset", pixel.valid, 1'b0);
    check_eq("interrupts after reset", irq, 2'b00);
  endtask

  task automatic registers_readback();
    logic [15:0] r;
    logic [7:0]  lcdc_v;
    logic [7:0]  scy_v;
    logic [7:0]  scx_v;
    logic [7:0]  lyc_v;
    logic [7:0]  bgp_v;
    logic [7:0]  stat_v;
    logic [7:0]  got;
    // LCD kept off
    rand_bits(8, r);
    lcdc_v = r[7:0] & 8'h7F;
    rand_bits(8, r);
    scy_v = r[7:0];
    rand_bits(8, r);
    scx_v = r[7:0];
    rand_bits(8, r);
    lyc_v = r[7:0];
    rand_bits(8, r);
    bgp_v = r[7:0];
    wb_write(ppu_pkg::REG_LCDC, lcdc_v);
    wb_write(ppu_pkg::REG_SCY, scy_v);
    wb_write(ppu_pkg::REG_SCX, scx_v);
    wb_write(ppu_pkg::REG_LYC, lyc_v);
    wb_write(ppu_pkg::REG_BGP, bgp_v);
    wb_read(ppu_pkg::REG_LCDC, got);
    check_eq("LCDC readback", got, lcdc_v);
    wb_read(ppu_pkg::REG_SCY, got);
    check_eq("SCY readback", got, scy_v);
    wb_read(ppu_pkg::REG_SCX, got);
    check_eq("SCX readback", got, scx_v);
    wb_read(ppu_pkg::REG_LYC, got);
    check_eq("LYC readback", got, lyc_v);
    wb_read(ppu_pkg::REG_BGP, got);
    check_eq("BGP readback", got, bgp_v);
    // LY is read-only
    rand_bits(8, r);
    wb_write(ppu_pkg::REG_LY, r[7:0]);
    wb_read(ppu_pkg::REG_LY, got);
    check_eq("LY after write", got, 8'h00);
    // Bit 7 high, enables, LY == LYC with LY at 0, mode 2
    rand_bits(8, r);
    stat_v = r[7:0];
    wb_write(ppu_pkg::REG_STAT, stat_v);
    wb_read(ppu_pkg::REG_STAT, got);
    check_eq("STAT readback", got, {1'b1, stat_v[6:3], (lyc_v == 8'd0), 2'd2});
    // Open bus
    wb_read(16'hFF4C, got);
    check_eq("unmapped FF4C", got, 8'hFF);
    wb_read(16'hA000, got);
    check_eq("unmapped A000", got, 8'hFF);
  endtask

  task automatic memory_readback();
    logic [15:0] r;
    logic [7:0]  got;
    int          i;
    for (i = 0; i < NUM_SAMPLES; i++) begin
      rand_bits(13, r);
      vram_addrs[i] = r[12:0];
      rand_bits(8, r);
      vram_model[vram_addrs[i]] = r[7:0];
      wb_write(ppu_pkg::VRAM_START + {3'b000, vram_addrs[i]}, r[7:0]);
    end
    for (i = 0; i < NUM_SAMPLES; i++) begin
      wb_read(ppu_pkg::VRAM_START + {3'b000, vram_addrs[i]}, got);
      check_eq($sformatf("VRAM %h", vram_addrs[i]), got, vram_model[vram_addrs[i]]);
    end
    // LCD off parks in mode 2, OAM closed
    wb_read(ppu_pkg::OAM_START, got);
    check_eq("OAM with LCD off", got, 8'hFF);
    // VBlank leaves OAM open for 4560 cycles
    wb_write(ppu_pkg::REG_LCDC, 8'h80);
    wait_vblank();
    for (i = 0; i < NUM_SAMPLES; i++) begin
      rand_bits(8, r);
      oam_offs[i] = r[7:0] % OAM_BYTES;
      rand_bits(8, r);
      oam_model[oam_offs[i]] = r[7:0];
      wb_write(ppu_pkg::OAM_START + {8'h00, oam_offs[i]}, r[7:0]);
    end
    for (i = 0; i < NUM_SAMPLES; i++) begin
      wb_read(ppu_pkg::OAM_START + {8'h00, oam_offs[i]}, got);
      check_eq($sformatf("OAM %h", oam_offs[i]), got, oam_model[oam_offs[i]]);
    end
  endtask

  task automatic mode_blocking();
    logic [7:0]  got;
    logic [15:0] vram_adr;
    logic [15:0] oam_adr;
    vram_adr = ppu_pkg::VRAM_START + {3'b000, vram_addrs[0]};
    oam_adr  = ppu_pkg::OAM_START + {8'h00, oam_offs[0]};
    // Catch mode 3 near its start
    wait_mode(2'd0);
    wait_mode(2'd3);
    wb_read(vram_adr, got);
    check_eq("VRAM read in mode 3", got, 8'hFF);
    wb_write(vram_adr, ~vram_model[vram_addrs[0]]);
    wb_read(oam_adr, got);
    check_eq("OAM read in mode 3", got, 8'hFF);
    wait_mode(2'd0);
    wb_read(vram_adr, got);
    check_eq("VRAM after mode 3 write", got, vram_model[vram_addrs[0]]);
    wait_mode(2'd2);
    wb_read(oam_adr, got);
    check_eq("OAM read in mode 2", got, 8'hFF);
  endtask

  task automatic frame_timing();
    int         cycles;
    logic [7:0] got;
    wait_vblank();
    cycles = 0;
    do begin
      step();
      cycles++;
    end while (!irq.vblank);
    check_eq("cycles between VBlank pulses", cycles, FRAME_CYCLES);
    wb_read(ppu_pkg::REG_LY, got);
    check_eq("LY after VBlank pulse", got, ppu_pkg::SCREEN_HEIGHT);
  endtask

  // Runs from the start of VBlank, so one frame ends at the next pulse
  task automatic stat_interrupt();
    int         start;
    logic [7:0] got;
    wb_write(ppu_pkg::REG_LYC, 8'd10);
    // LYC enable only
    wb_write(ppu_pkg::REG_STAT, 8'h40);
    wb_read(ppu_pkg::REG_STAT, got);
    check_eq("STAT in VBlank", got, 8'hC1);
    start = stat_count;
    do begin
      step();
    end while (!irq.stat);
    wb_read(ppu_pkg::REG_LY, got);
    check_eq("LY at STAT pulse", got, 8'd10);
    wb_read(ppu_pkg::REG_STAT, got);
    check_eq("coincidence on line 10", got[2], 1'b1);
    wait_vblank();
    check_eq("STAT pulses in one frame", stat_count - start, 1);
  endtask

  task automatic background_pixels();
    logic [15:0] r;
    int          i;
    int          k;
    int          x;
    int          line;
    wb_write(ppu_pkg::REG_LCDC, 8'h00);
    wb_write(ppu_pkg::REG_STAT, 8'h00);
    // Random maps and tile data over all of VRAM
    for (i = 0; i < VRAM_BYTES; i++) begin
      rand_bits(8, r);
      vram_model[i] = r[7:0];
      wb_write(ppu_pkg::VRAM_START + 16'(i), r[7:0]);
    end
    rand_bits(8, r);
    pix_scx = r[7:0];
    rand_bits(8, r);
    pix_scy = r[7:0];
    rand_bits(8, r);
    pix_bgp = r[7:0];
    // LCD on, map at 9C00, signed tile indices
    pix_lcdc = 8'h88;
    wb_write(ppu_pkg::REG_SCX, pix_scx);
    wb_write(ppu_pkg::REG_SCY, pix_scy);
    wb_write(ppu_pkg::REG_BGP, pix_bgp);
    wb_write(ppu_pkg::REG_LCDC, pix_lcdc);
    k = 0;
    while (!irq.vblank) begin
      if (pixel.valid) begin
        x    = k % ppu_pkg::SCREEN_WIDTH;
        line = k / ppu_pkg::SCREEN_WIDTH;
        if (line < ppu_pkg::SCREEN_HEIGHT) begin
          check_eq($sformatf("pixel x=%0d line=%0d", x, line), pixel.shade,
                   expected_shade(x, line));
        end
        k++;
      end
      step();
    end
    check_eq("pixels in first frame", k, FRAME_PIXELS);
  endtask

  // ====================================================================
  // Sequence and watchdog
  // ====================================================================

  initial begin
    wb_req     = '0;
    reset      = 1'b1;
    mismatches = 0;
    failures   = 0;
    lfsr_state = LFSR_SEED;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    reset_state();
    registers_readback();
    memory_readback();
    mode_blocking();
    frame_timing();
    stat_interrupt();
    background_pixels();
    report_counts();
    if (mismatches + failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    failures++;
    report_counts();
    $display("TB FAILED");
    $finish;
  end

endmodule
